/* source/uart_pkg.sv */
package uart_pkg;

  // clock cycles per serial bit
  // kept short for simulation, a 50 MHz part at 115200 baud would use 434
  localparam int clks_per_bit = 8;

  // start, eight data, parity, stop
  localparam int frame_bits = 11;

  localparam int baud_cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

  // counts 0 .. clks_per_bit-1 inside one bit
  typedef logic [baud_cnt_w-1:0] baud_cnt_t;

  // position inside a frame
  typedef logic [3:0] bit_cnt_t;

  // one serial payload
  typedef logic [7:0] byte_t;

endpackage

/* source/cmd_pkg.sv */
package cmd_pkg;

  localparam int cmd_width = 16;

  // read flag position, 1 = read
  localparam int rw_bit = 15;

  // cycles to wait after the last frame before a read gives up
  localparam int reply_timeout_clks = 2 * uart_pkg::frame_bits * uart_pkg::clks_per_bit;

  localparam int timeout_w = $clog2(reply_timeout_clks + 1);

  // {rw, addr[6:0], data[7:0]}
  typedef logic [cmd_width-1:0] cmd_t;

  typedef logic [6:0] addr_t;

  typedef logic [7:0] data_t;

  typedef logic [timeout_w-1:0] timeout_cnt_t;

endpackage

/* source/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::byte_t tx_byte,
  input  logic            tx_vld,
  output logic            tx_rdy,
  output logic            tx
);

  logic                            busy;
  logic [uart_pkg::frame_bits-2:0] shreg;
  uart_pkg::baud_cnt_t             baud_cnt;
  uart_pkg::bit_cnt_t              bit_cnt;
  logic                            accept;
  logic                            bit_end;
  logic                            last_bit;

  assign accept   = tx_vld && tx_rdy;
  assign bit_end  = baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::clks_per_bit - 1);
  assign last_bit = bit_cnt == uart_pkg::bit_cnt_t'(uart_pkg::frame_bits - 1);

  // ready again once the stop bit has had its full bit time
  assign tx_rdy = !busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;
    end else if (accept) begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      // start bit goes out right away
      tx       <= 1'b0;
    end else if (busy) begin
      if (bit_end) begin
        baud_cnt <= '0;
        if (last_bit) begin
          // stop bit done, line stays high
          busy <= 1'b0;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
          tx      <= shreg[0];
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // rest of the frame: data lsb first, odd parity, stop
  always_ff @(posedge clk) begin
    if (accept) begin
      shreg <= {1'b1, ~^tx_byte, tx_byte};
    end else if (busy && bit_end && !last_bit) begin
      shreg <= {1'b1, shreg[uart_pkg::frame_bits-2:1]};
    end
  end

endmodule

/* source/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rx,
  output uart_pkg::byte_t rx_byte,
  output logic            rx_done,
  output logic            rx_bad,
  output logic            rx_busy
);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

  rx_state_t           state;
  logic                rx_meta;
  logic                rx_sync;
  logic                rx_prev;
  uart_pkg::baud_cnt_t baud_cnt;
  uart_pkg::bit_cnt_t  bit_cnt;
  logic                parity;
  logic                half_end;
  logic                bit_end;
  logic                parity_bit;

  assign half_end   = baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::clks_per_bit / 2 - 1);
  assign bit_end    = baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::clks_per_bit - 1);
  assign parity_bit = bit_cnt == uart_pkg::bit_cnt_t'($bits(uart_pkg::byte_t));
  assign rx_busy    = state != rx_idle;

  // two flop synchronizer plus one more for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= rx_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      parity   <= 1'b0;
      rx_done  <= 1'b0;
      rx_bad   <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      rx_bad  <= 1'b0;
      case (state)
        rx_idle: begin
          if (rx_prev && !rx_sync) begin
            state    <= rx_start;
            baud_cnt <= '0;
          end
        end
        rx_start: begin
          if (half_end) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            parity   <= 1'b0;
            // start bit gone high again, treat as a glitch
            state    <= rx_sync ? rx_idle : rx_data;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rx_data: begin
          if (bit_end) begin
            baud_cnt <= '0;
            parity   <= parity ^ rx_sync;
            if (parity_bit) begin
              state <= rx_stop;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rx_stop: begin
          if (bit_end) begin
            state <= rx_idle;
            // odd count of ones over data and parity
            if (parity && rx_sync) begin
              rx_done <= 1'b1;
            end else begin
              rx_bad <= 1'b1;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // lsb arrives first
  always_ff @(posedge clk) begin
    if (state == rx_data && bit_end && !parity_bit) begin
      rx_byte <= {rx_sync, rx_byte[$bits(uart_pkg::byte_t)-1:1]};
    end
  end

endmodule

/* source/cmd_sequencer.sv */
`timescale 1ns/1ns

module cmd_sequencer (
  input  logic            clk,
  input  logic            rst_n,
  input  cmd_pkg::cmd_t   cmd,
  input  logic            cmd_vld,
  output logic            cmd_rdy,
  output uart_pkg::byte_t tx_byte,
  output logic            tx_vld,
  input  logic            tx_rdy,
  input  uart_pkg::byte_t rx_byte,
  input  logic            rx_done,
  input  logic            rx_bad,
  input  logic            rx_busy,
  output logic            read_vld,
  output cmd_pkg::data_t  read_data,
  output logic            read_err
);

  typedef enum logic [2:0] {
    seq_idle,
    seq_send_hi,
    seq_send_lo,
    seq_wait_reply,
    seq_report
  } seq_state_t;

  seq_state_t            state;
  cmd_pkg::cmd_t         cmd_r;
  cmd_pkg::addr_t        cmd_addr;
  cmd_pkg::data_t        cmd_data;
  cmd_pkg::timeout_cnt_t timer;
  logic                  lo_sent;
  logic                  read_ok;
  logic                  accept;
  logic                  tx_take;
  logic                  timer_run;
  logic                  timed_out;

  assign cmd_addr = cmd_r[cmd_pkg::rw_bit-1:$bits(cmd_pkg::data_t)];
  assign cmd_data = cmd_r[$bits(cmd_pkg::data_t)-1:0];

  // report cycle also takes the next command
  assign cmd_rdy = (state == seq_idle) || (state == seq_report);
  assign accept  = cmd_vld && cmd_rdy;

  assign tx_vld  = (state == seq_send_hi) || ((state == seq_send_lo) && !lo_sent);
  assign tx_byte = (state == seq_send_lo) ? cmd_data : {cmd_r[cmd_pkg::rw_bit], cmd_addr};
  assign tx_take = tx_vld && tx_rdy;

  // timeout only counts once the request frame is off the line
  assign timer_run = tx_rdy && !rx_busy;
  assign timed_out = timer_run &&
                     (timer == cmd_pkg::timeout_cnt_t'(cmd_pkg::reply_timeout_clks - 1));

  assign read_vld = (state == seq_report) && read_ok;
  assign read_err = (state == seq_report) && !read_ok;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= seq_idle;
      lo_sent <= 1'b0;
      read_ok <= 1'b0;
      timer   <= '0;
    end else begin
      case (state)
        seq_idle, seq_report: begin
          if (accept) begin
            state <= seq_send_hi;
          end else begin
            state <= seq_idle;
          end
        end
        seq_send_hi: begin
          if (tx_take) begin
            lo_sent <= 1'b0;
            timer   <= '0;
            state   <= cmd_r[cmd_pkg::rw_bit] ? seq_wait_reply : seq_send_lo;
          end
        end
        seq_send_lo: begin
          if (tx_take) begin
            lo_sent <= 1'b1;
          end else if (lo_sent && tx_rdy) begin
            // data frame fully out
            state <= seq_idle;
          end
        end
        seq_wait_reply: begin
          if (rx_done) begin
            read_ok <= 1'b1;
            state   <= seq_report;
          end else if (rx_bad || timed_out) begin
            read_ok <= 1'b0;
            state   <= seq_report;
          end else if (timer_run) begin
            timer <= timer + 1'b1;
          end
        end
        default: state <= seq_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_r <= cmd;
    end
    if (state == seq_wait_reply && rx_done) begin
      read_data <= rx_byte;
    end
  end

endmodule

/* source/uart_cmd_bridge.sv */
`timescale 1ns/1ns

module uart_cmd_bridge (
  input  logic           clk,
  input  logic           rst_n,
  input  cmd_pkg::cmd_t  cmd,
  input  logic           cmd_vld,
  output logic           cmd_rdy,
  output logic           read_vld,
  output cmd_pkg::data_t read_data,
  output logic           read_err,
  output logic           tx,
  input  logic           rx
);

  uart_pkg::byte_t tx_byte;
  logic            tx_vld;
  logic            tx_rdy;
  uart_pkg::byte_t rx_byte;
  logic            rx_done;
  logic            rx_bad;
  logic            rx_busy;

  cmd_sequencer seq_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_byte   (tx_byte),
    .tx_vld    (tx_vld),
    .tx_rdy    (tx_rdy),
    .rx_byte   (rx_byte),
    .rx_done   (rx_done),
    .rx_bad    (rx_bad),
    .rx_busy   (rx_busy),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx tx_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_byte (tx_byte),
    .tx_vld  (tx_vld),
    .tx_rdy  (tx_rdy),
    .tx      (tx)
  );

  uart_rx rx_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_byte (rx_byte),
    .rx_done (rx_done),
    .rx_bad  (rx_bad),
    .rx_busy (rx_busy)
  );

endmodule

/* test/uart_peer_model.sv */
`timescale 1ns/1ns

module uart_peer_model (
  input  logic clk,
  input  logic rst_n,
  input  logic tx,
  output logic rx
);

  localparam int bit_clks = uart_pkg::clks_per_bit;

  uart_pkg::byte_t req;
  logic            start_ok;
  logic            data_next;

  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk);
  endtask

  // entered on the first falling edge that sees the start bit
  task automatic receive_frame(output uart_pkg::byte_t b, output logic ok);
    b = '0;
    wait_clks(bit_clks / 2);
    ok = !tx;
    if (ok) begin
      for (int i = 0; i < 8; i++) begin
        wait_clks(bit_clks);
        b[i] = tx;
      end
      // skip over parity, stop at mid-bit
      wait_clks(2 * bit_clks);
    end
  endtask

  task automatic send_frame(input uart_pkg::byte_t b, input logic bad_parity);
    logic [uart_pkg::frame_bits-1:0] bits;
    bits = {1'b1, (~^b) ^ bad_parity, b, 1'b0};
    for (int i = 0; i < uart_pkg::frame_bits - 1; i++) begin
      rx = bits[i];
      wait_clks(bit_clks);
    end
    // stop bit runs on as idle line
    rx = 1'b1;
  endtask

  initial begin
    rx        = 1'b1;
    data_next = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && !tx) begin
        receive_frame(req, start_ok);
        if (start_ok && data_next) begin
          // data byte of a write, nothing to answer
          data_next = 1'b0;
        end else if (start_ok && !req[7]) begin
          // write header with its data byte next
          data_next = 1'b1;
        end else if (start_ok && req[6:0] != 7'h7E) begin
          // read request, 7E never answers, 7F answers with broken parity
          wait_clks(3 * bit_clks);
          send_frame({1'b0, req[6:0]} ^ 8'hA5, req[6:0] == 7'h7F);
        end
      end
    end
  end

endmodule

/* test/tb_uart_cmd_bridge.sv */
`timescale 1ns/1ns

module tb_uart_cmd_bridge;

  localparam int clk_period  = 10;
  localparam int frame_clks  = uart_pkg::frame_bits * uart_pkg::clks_per_bit;
  localparam int n_writes    = 10;
  localparam int n_reads     = 10;
  localparam int n_mixed     = 24;
  localparam int total_cmds  = n_writes + n_reads + 4 + n_mixed;
  // worst case per command plus the settle time after each test
  localparam int watchdog_ns = (total_cmds * (2 * frame_clks + cmd_pkg::reply_timeout_clks)
                               + 5 * frame_clks + 500) * clk_period;

  typedef enum logic [1:0] {outcome_none, outcome_data, outcome_err} outcome_t;

  typedef struct packed {
    logic [1:0]      n_frames;
    uart_pkg::byte_t frame0;
    uart_pkg::byte_t frame1;
    outcome_t        kind;
    cmd_pkg::data_t  data;
  } expect_t;

  typedef struct packed {
    outcome_t       kind;
    cmd_pkg::data_t data;
  } seen_t;

  logic           clk = 1'b0;
  logic           rst_n;
  cmd_pkg::cmd_t  cmd;
  logic           cmd_vld;
  logic           cmd_rdy;
  logic           read_vld;
  cmd_pkg::data_t read_data;
  logic           read_err;
  logic           tx;
  logic           rx;

  expect_t         exp_q[$];
  uart_pkg::byte_t frame_q[$];
  seen_t           seen_q[$];
  logic [15:0]     lfsr = 16'd27780;
  int              errors = 0;
  int              accepted = 0;
  int              completed = 0;
  int              tests_run = 0;
  int              tests_ok = 0;
  int              exp_frames = 0;
  int              exp_outcomes = 0;
  int              frames_got = 0;
  int              outcomes_got = 0;

  always #(clk_period / 2) clk = ~clk;

  uart_cmd_bridge dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_err  (read_err),
    .tx        (tx),
    .rx        (rx)
  );

  uart_peer_model peer_i (
    .clk   (clk),
    .rst_n (rst_n),
    .tx    (tx),
    .rx    (rx)
  );

  function automatic logic [15:0] galois_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr[0]};
      lfsr = galois_step(lfsr);
    end
  endtask

  // frames and outcome a command must produce
  function automatic expect_t expected_result(input cmd_pkg::cmd_t c);
    expect_t        r;
    cmd_pkg::addr_t a;
    a = c[14:8];
    r.frame0   = {c[15], a};
    r.frame1   = c[7:0];
    r.n_frames = c[15] ? 2'd1 : 2'd2;
    r.data     = {1'b0, a} ^ 8'hA5;
    if (!c[15])
      r.kind = outcome_none;
    else if (a == 7'h7F || a == 7'h7E)
      r.kind = outcome_err;
    else
      r.kind = outcome_data;
    return r;
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("at %0t ns: %s", $time, msg);
  endtask

  task automatic check_byte(input uart_pkg::byte_t got, input uart_pkg::byte_t exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input cmd_pkg::data_t got, input cmd_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_outcome(input outcome_t got, input outcome_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s is %s, expected %s", $time, what, got.name(),
               exp.name());
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic send_command(input cmd_pkg::cmd_t c);
    logic [15:0] v;
    logic [15:0] junk;
    expect_t     r;
    logic        sent;
    sent = 1'b0;
    while (!sent) begin
      @(negedge clk);
      if (cmd_rdy) begin
        cmd     = c;
        cmd_vld = 1'b1;
        r       = expected_result(c);
        exp_q.push_back(r);
        accepted++;
        exp_frames += r.n_frames;
        if (r.kind != outcome_none)
          exp_outcomes++;
        sent = 1'b1;
      end else begin
        // command in flight, anything offered now must be dropped
        take_bits(1, v);
        take_bits(16, junk);
        cmd     = junk;
        cmd_vld = v[0];
      end
    end
  endtask

  task automatic end_test(input string name, input int n_cmds, input int start_errors);
    @(negedge clk);
    cmd_vld = 1'b0;
    while (completed != accepted)
      @(negedge clk);
    repeat (frame_clks) @(negedge clk);
    check_level(cmd_rdy, 1'b1, "cmd_rdy after last command");
    if (frame_q.size() != 0 || seen_q.size() != 0)
      flag_error("frames or read pulses left over with no command behind them");
    tests_run++;
    if (errors == start_errors)
      tests_ok++;
    $display("%s: %0d commands, %0d errors", name, n_cmds, errors - start_errors);
  endtask

  // independent decoder of the tx line
  initial begin : tx_monitor
    uart_pkg::byte_t b;
    logic            par;
    forever begin
      @(negedge clk);
      if (rst_n && !tx) begin
        repeat (uart_pkg::clks_per_bit / 2) @(negedge clk);
        if (tx) begin
          flag_error("start bit on tx did not last to mid-bit");
        end else begin
          for (int i = 0; i < 8; i++) begin
            repeat (uart_pkg::clks_per_bit) @(negedge clk);
            b[i] = tx;
          end
          repeat (uart_pkg::clks_per_bit) @(negedge clk);
          par = tx;
          repeat (uart_pkg::clks_per_bit) @(negedge clk);
          if (^{b, par} !== 1'b1)
            flag_error("tx frame carries even parity");
          if (tx !== 1'b1)
            flag_error("tx frame has no stop bit");
          frame_q.push_back(b);
          frames_got++;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (read_vld && read_err)
        flag_error("read_vld and read_err high in the same cycle");
      if (read_vld) begin
        seen_q.push_back({outcome_data, read_data});
        outcomes_got++;
      end else if (read_err) begin
        seen_q.push_back({outcome_err, 8'h00});
        outcomes_got++;
      end
    end
  end

  // matches frames and outcomes against commands in acceptance order
  initial begin : compare
    expect_t cur;
    seen_t   got;
    int      n_done;
    n_done = 0;
    forever begin
      @(posedge clk);
      if (exp_q.size() > 0) begin
        cur = exp_q[0];
        if (n_done < cur.n_frames && frame_q.size() > 0) begin
          check_byte(frame_q.pop_front(), (n_done == 0) ? cur.frame0 : cur.frame1,
                     "tx frame byte");
          n_done++;
        end
        if (n_done == cur.n_frames && (cur.kind == outcome_none || seen_q.size() > 0)) begin
          if (cur.kind != outcome_none) begin
            got = seen_q.pop_front();
            check_outcome(got.kind, cur.kind, "read outcome");
            if (cur.kind == outcome_data && got.kind == outcome_data)
              check_data(got.data, cur.data, "read_data");
          end
          cur = exp_q.pop_front();
          n_done = 0;
          completed++;
        end
      end
    end
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("run did not finish within %0d ns, stopped by the watchdog", watchdog_ns);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [15:0] v;
    int          start;
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_vld = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    start = errors;
    repeat (6) begin
      @(negedge clk);
      check_level(tx, 1'b1, "tx after reset");
      check_level(cmd_rdy, 1'b1, "cmd_rdy after reset");
      check_level(read_vld | read_err, 1'b0, "read pulse after reset");
    end
    end_test("reset state", 0, start);

    start = errors;
    repeat (n_writes) begin
      take_bits(15, v);
      send_command({1'b0, v[14:0]});
    end
    end_test("writes", n_writes, start);

    start = errors;
    repeat (n_reads) begin
      take_bits(15, v);
      // keep clear of the two addresses the peer treats specially
      if (v[14:8] >= 7'h7E)
        v[14] = 1'b0;
      send_command({1'b1, v[14:0]});
    end
    end_test("reads", n_reads, start);

    start = errors;
    send_command({1'b1, 7'h7F, 8'h00});
    send_command({1'b1, 7'h7E, 8'h00});
    send_command({1'b1, 7'h7E, 8'h3C});
    send_command({1'b1, 7'h7F, 8'hC3});
    end_test("reply errors", 4, start);

    start = errors;
    repeat (n_mixed) begin
      take_bits(16, v);
      send_command(v);
    end
    end_test("mixed", n_mixed, start);

    if (frames_got != exp_frames || outcomes_got != exp_outcomes)
      flag_error("number of frames or outcomes differs from the accepted commands");
    $display("%0d of %0d tests passed, %0d commands, %0d frames, %0d outcomes, %0d errors",
             tests_ok, tests_run, accepted, frames_got, outcomes_got, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
source/uart_pkg.sv
source/cmd_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/cmd_sequencer.sv
source/uart_cmd_bridge.sv
test/uart_peer_model.sv
test/tb_uart_cmd_bridge.sv

/* Bender.yml */
package:
  name: uart_cmd_bridge

sources:
  - files:
      - source/uart_pkg.sv
      - source/cmd_pkg.sv
      - source/uart_tx.sv
      - source/uart_rx.sv
      - source/cmd_sequencer.sv
      - source/uart_cmd_bridge.sv

  - target: test
    files:
      - test/uart_peer_model.sv
      - test/tb_uart_cmd_bridge.sv
